// ==== design/antitoken_tracker.sv ====
module antitoken_tracker (
  input  logic clk,
  input  logic reset,
  input  logic pvalid      [2],
  input  logic generate_at [2],
  output logic kill        [2],
  output logic stop_valid
);

  import dataflow_pkg::*;

  logic flag [2];

  // flag waits for the late token on its side
  always_ff @(posedge clk) begin
    if (!reset) begin
      flag[SIDE_TRUE]  <= 1'b0;
      flag[SIDE_FALSE] <= 1'b0;
    end else begin
      for (int s = 0; s < 2; s++) begin
        flag[s] <= !pvalid[s] && (generate_at[s] || flag[s]);
      end
    end
  end

  for (genvar s = 0; s < 2; s++) begin : g_kill
    assign kill[s] = generate_at[s] || flag[s];  // drop whatever shows up
  end

  assign stop_valid = flag[SIDE_TRUE] || flag[SIDE_FALSE];

  // selector only skips the side it did not pick
  a_one_side: assert property (
    @(posedge clk) disable iff (!reset)
    !(generate_at[SIDE_TRUE] && generate_at[SIDE_FALSE])
  );

endmodule

// ==== design/arith_branch.sv ====
module arith_branch #(
  parameter dataflow_pkg::branch_op_e OP = dataflow_pkg::OP_ADD,
  parameter int WIDTH   = 32,
  parameter int LATENCY = 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] a_data,
  input  logic             a_valid,
  output logic             a_ready,
  input  logic [WIDTH-1:0] b_data,
  input  logic             b_valid,
  output logic             b_ready,
  output logic [WIDTH-1:0] res_data,
  output logic             res_valid,
  input  logic             res_ready
);

  import dataflow_pkg::*;

  logic [MAX_WIDTH-1:0] op_full;
  logic [WIDTH-1:0]     op_res;
  logic                 join_fire;

  logic [LATENCY-1:0] stage_valid;
  logic [LATENCY-1:0] stage_adv;
  logic [LATENCY-1:0] stage_in_valid;
  logic [WIDTH-1:0]   stage_data    [LATENCY];
  logic [WIDTH-1:0]   stage_in_data [LATENCY];

  if (LATENCY < 1) begin : g_bad_latency
    $error("arith_branch needs LATENCY >= 1");
  end
  if (WIDTH > MAX_WIDTH) begin : g_bad_width
    $error("arith_branch WIDTH above MAX_WIDTH");
  end

  assign op_full = apply_op(OP, MAX_WIDTH'(a_data), MAX_WIDTH'(b_data), WIDTH);
  assign op_res  = op_full[WIDTH-1:0];

  // join of both operands into stage 0
  assign join_fire = a_valid && b_valid && stage_adv[0];
  assign a_ready   = b_valid && stage_adv[0];
  assign b_ready   = a_valid && stage_adv[0];

  for (genvar i = 0; i < LATENCY; i++) begin : g_stage
    if (i == 0) begin : g_first
      assign stage_in_valid[i] = join_fire;
      assign stage_in_data[i]  = op_res;
    end else begin : g_next
      assign stage_in_valid[i] = stage_valid[i-1];
      assign stage_in_data[i]  = stage_data[i-1];
    end

    // empty stages take new data, so bubbles collapse
    if (i == LATENCY - 1) begin : g_last
      assign stage_adv[i] = !stage_valid[i] || res_ready;
    end else begin : g_mid
      assign stage_adv[i] = !stage_valid[i] || stage_adv[i+1];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      stage_valid <= '0;
    end else begin
      for (int i = 0; i < LATENCY; i++) begin
        if (stage_adv[i]) stage_valid[i] <= stage_in_valid[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < LATENCY; i++) begin
      if (stage_adv[i]) stage_data[i] <= stage_in_data[i];
    end
  end

  assign res_data  = stage_data[LATENCY-1];
  assign res_valid = stage_valid[LATENCY-1];

  // operands stay offered until the join takes them
  a_a_hold: assert property (
    @(posedge clk) disable iff (!reset)
    a_valid && !a_ready |=> a_valid && $stable(a_data)
  );

  a_b_hold: assert property (
    @(posedge clk) disable iff (!reset)
    b_valid && !b_ready |=> b_valid && $stable(b_data)
  );

endmodule

// ==== design/dataflow_pkg.sv ====
package dataflow_pkg;

  typedef enum logic [0:0] {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } branch_op_e;

  // selector input index
  typedef enum logic [0:0] {
    SIDE_TRUE  = 1'b0,  // adder
    SIDE_FALSE = 1'b1   // subtractor
  } sel_side_e;

  localparam int DEFAULT_WIDTH = 32;
  localparam int MAX_WIDTH     = 64;

  // result wraps modulo 2^width
  function automatic logic [MAX_WIDTH-1:0] apply_op(
    input branch_op_e           op,
    input logic [MAX_WIDTH-1:0] a,
    input logic [MAX_WIDTH-1:0] b,
    input int unsigned          width
  );
    logic [MAX_WIDTH-1:0] mask;
    logic [MAX_WIDTH-1:0] raw;
    mask = (width >= MAX_WIDTH) ? '1 : ((MAX_WIDTH'(1) << width) - 1'b1);
    raw  = (op == OP_ADD) ? (a + b) : (a - b);
    return raw & mask;
  endfunction

endpackage

// ==== design/eager_fork.sv ====
module eager_fork #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out0_data,
  output logic     out0_valid,
  input  logic     out0_ready,
  output payload_t out1_data,
  output logic     out1_valid,
  input  logic     out1_ready
);

  logic sent0;
  logic sent1;
  logic done0;
  logic done1;

  assign out0_data = in_data;
  assign out1_data = in_data;

  // each copy shown until taken once
  assign out0_valid = in_valid && !sent0;
  assign out1_valid = in_valid && !sent1;

  assign done0 = sent0 || out0_ready;
  assign done1 = sent1 || out1_ready;

  // release input with the last copy
  assign in_ready = done0 && done1;

  always_ff @(posedge clk) begin
    if (!reset) begin
      sent0 <= 1'b0;
      sent1 <= 1'b0;
    end else if (in_valid && in_ready) begin
      sent0 <= 1'b0;  // token fully delivered
      sent1 <= 1'b0;
    end else begin
      sent0 <= sent0 || (out0_valid && out0_ready);
      sent1 <= sent1 || (out1_valid && out1_ready);
    end
  end

  // upstream keeps its token steady until both consumers took it
  a_in_stable: assert property (
    @(posedge clk) disable iff (!reset)
    in_valid && !in_ready |=> in_valid && $stable(in_data)
  );

endmodule

// ==== design/elastic_fifo.sv ====
module elastic_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             out_valid_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign push      = in_valid && in_ready;
  assign pop       = out_valid_q && out_ready;
  assign out_valid = out_valid_q;
  assign out_data  = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (push && !pop) count_next = count + 1'b1;
    else if (pop && !push) count_next = count - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      count       <= count_next;
      out_valid_q <= (count_next != '0);  // new entry visible next cycle
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!reset)
    count <= CNT_W'(DEPTH)
  );

  // registered valid must track the count
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!reset)
    pop |-> count != '0
  );

endmodule

// ==== design/spec_select_top.sv ====
module spec_select_top #(
  parameter int WIDTH       = dataflow_pkg::DEFAULT_WIDTH,
  parameter int ADD_LATENCY = 1,
  parameter int SUB_LATENCY = 3,
  parameter int COND_DEPTH  = 4,
  parameter int OUT_DEPTH   = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] a_data,
  input  logic             a_valid,
  output logic             a_ready,
  input  logic [WIDTH-1:0] b_data,
  input  logic             b_valid,
  output logic             b_ready,
  input  logic             cond,
  input  logic             cond_valid,
  output logic             cond_ready,
  output logic [WIDTH-1:0] result,
  output logic             result_valid,
  input  logic             result_ready
);

  import dataflow_pkg::*;

  // fork outputs, add side and sub side
  logic [WIDTH-1:0] fa_add_data;
  logic             fa_add_valid;
  logic             fa_add_ready;
  logic [WIDTH-1:0] fa_sub_data;
  logic             fa_sub_valid;
  logic             fa_sub_ready;
  logic [WIDTH-1:0] fb_add_data;
  logic             fb_add_valid;
  logic             fb_add_ready;
  logic [WIDTH-1:0] fb_sub_data;
  logic             fb_sub_valid;
  logic             fb_sub_ready;

  logic [WIDTH-1:0] add_data;
  logic             add_valid;
  logic             add_ready;
  logic [WIDTH-1:0] sub_data;
  logic             sub_valid;
  logic             sub_ready;

  logic             cf_data;
  logic             cf_valid;
  logic             cf_ready;
  logic [WIDTH-1:0] sel_data;
  logic             sel_valid;
  logic             sel_ready;

  eager_fork #(.payload_t(logic [WIDTH-1:0])) fork_a (
    .clk(clk), .reset(reset),
    .in_data(a_data), .in_valid(a_valid), .in_ready(a_ready),
    .out0_data(fa_add_data), .out0_valid(fa_add_valid), .out0_ready(fa_add_ready),
    .out1_data(fa_sub_data), .out1_valid(fa_sub_valid), .out1_ready(fa_sub_ready)
  );

  eager_fork #(.payload_t(logic [WIDTH-1:0])) fork_b (
    .clk(clk), .reset(reset),
    .in_data(b_data), .in_valid(b_valid), .in_ready(b_ready),
    .out0_data(fb_add_data), .out0_valid(fb_add_valid), .out0_ready(fb_add_ready),
    .out1_data(fb_sub_data), .out1_valid(fb_sub_valid), .out1_ready(fb_sub_ready)
  );

  // both branches run on every pair
  arith_branch #(.OP(OP_ADD), .WIDTH(WIDTH), .LATENCY(ADD_LATENCY)) add_branch (
    .clk(clk), .reset(reset),
    .a_data(fa_add_data), .a_valid(fa_add_valid), .a_ready(fa_add_ready),
    .b_data(fb_add_data), .b_valid(fb_add_valid), .b_ready(fb_add_ready),
    .res_data(add_data), .res_valid(add_valid), .res_ready(add_ready)
  );

  arith_branch #(.OP(OP_SUB), .WIDTH(WIDTH), .LATENCY(SUB_LATENCY)) sub_branch (
    .clk(clk), .reset(reset),
    .a_data(fa_sub_data), .a_valid(fa_sub_valid), .a_ready(fa_sub_ready),
    .b_data(fb_sub_data), .b_valid(fb_sub_valid), .b_ready(fb_sub_ready),
    .res_data(sub_data), .res_valid(sub_valid), .res_ready(sub_ready)
  );

  elastic_fifo #(.payload_t(logic), .DEPTH(COND_DEPTH)) cond_fifo (
    .clk(clk), .reset(reset),
    .in_data(cond), .in_valid(cond_valid), .in_ready(cond_ready),
    .out_data(cf_data), .out_valid(cf_valid), .out_ready(cf_ready)
  );

  speculative_select #(.WIDTH(WIDTH)) select0 (
    .clk(clk), .reset(reset),
    .cond(cf_data), .cond_valid(cf_valid), .cond_ready(cf_ready),
    .true_data(add_data), .true_valid(add_valid), .true_ready(add_ready),
    .false_data(sub_data), .false_valid(sub_valid), .false_ready(sub_ready),
    .result(sel_data), .result_valid(sel_valid), .result_ready(sel_ready)
  );

  elastic_fifo #(.payload_t(logic [WIDTH-1:0]), .DEPTH(OUT_DEPTH)) out_fifo (
    .clk(clk), .reset(reset),
    .in_data(sel_data), .in_valid(sel_valid), .in_ready(sel_ready),
    .out_data(result), .out_valid(result_valid), .out_ready(result_ready)
  );

endmodule

// ==== design/speculative_select.sv ====
module speculative_select #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             cond,
  input  logic             cond_valid,
  output logic             cond_ready,
  input  logic [WIDTH-1:0] true_data,
  input  logic             true_valid,
  output logic             true_ready,
  input  logic [WIDTH-1:0] false_data,
  input  logic             false_valid,
  output logic             false_ready,
  output logic [WIDTH-1:0] result,
  output logic             result_valid,
  input  logic             result_ready
);

  import dataflow_pkg::*;

  logic early_valid;
  logic fire_valid;
  logic out_fire;
  logic stop_valid;
  logic pvalid      [2];
  logic generate_at [2];
  logic kill        [2];

  // cond plus the side it picks, other side not needed
  assign early_valid = cond_valid && (cond ? true_valid : false_valid);
  assign fire_valid  = early_valid && !stop_valid;
  assign out_fire    = fire_valid && result_ready;

  assign pvalid[SIDE_TRUE]  = true_valid;
  assign pvalid[SIDE_FALSE] = false_valid;

  // antitoken only for a side still missing
  assign generate_at[SIDE_TRUE]  = out_fire && !true_valid;
  assign generate_at[SIDE_FALSE] = out_fire && !false_valid;

  assign true_ready  = !true_valid || out_fire || kill[SIDE_TRUE];
  assign false_ready = !false_valid || out_fire || kill[SIDE_FALSE];
  assign cond_ready  = !cond_valid || out_fire;

  assign result       = cond ? true_data : false_data;
  assign result_valid = fire_valid;

  antitoken_tracker tracker0 (
    .clk         (clk),
    .reset       (reset),
    .pvalid      (pvalid),
    .generate_at (generate_at),
    .kill        (kill),
    .stop_valid  (stop_valid)
  );

endmodule

// ==== dv/tb_spec_select.sv ====
module tb_spec_select;

  timeunit 1ns;
  timeprecision 100ps;

  import dataflow_pkg::*;

  localparam int W           = DEFAULT_WIDTH;
  localparam int SEED        = 89;
  localparam int TOTAL_ITEMS = 2 + 64 + 24 + 40 + 16 + 8;
  localparam int CYCLE_LIMIT = 50 * TOTAL_ITEMS + 200;
  localparam int DRAIN_IDLE  = 10;  // quiet cycles to catch stray results

  logic         clk;
  logic         reset        = 1'b0;
  logic [W-1:0] a_data       = '0;
  logic         a_valid      = 1'b0;
  logic         a_ready;
  logic [W-1:0] b_data       = '0;
  logic         b_valid      = 1'b0;
  logic         b_ready;
  logic         cond         = 1'b0;
  logic         cond_valid   = 1'b0;
  logic         cond_ready;
  logic [W-1:0] result;
  logic         result_valid;
  logic         result_ready = 1'b1;

  logic [W-1:0] a_q     [$];
  logic [W-1:0] b_q     [$];
  logic         c_q     [$];
  logic [W-1:0] model_q [$];
  int unsigned  lcg_state [5];  // 0 stimulus, 1..3 channel gaps, 4 result_ready

  bit a_xfer       = 1'b0;
  bit b_xfer       = 1'b0;
  bit c_xfer       = 1'b0;
  bit hold_ab      = 1'b0;
  bit hold_c       = 1'b0;
  bit stall_en     = 1'b0;
  bit a_blocked    = 1'b0;
  int max_gap      = 0;
  int rr_run       = 0;
  int result_count = 0;
  int cycle_count  = 0;

  spec_select_top dut0 (
    .clk(clk), .reset(reset),
    .a_data(a_data), .a_valid(a_valid), .a_ready(a_ready),
    .b_data(b_data), .b_valid(b_valid), .b_ready(b_ready),
    .cond(cond), .cond_valid(cond_valid), .cond_ready(cond_ready),
    .result(result), .result_valid(result_valid), .result_ready(result_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int unsigned lcg_next(input int idx);
    lcg_state[idx] = lcg_state[idx] * 32'd1664525 + 32'd1013904223;
    return lcg_state[idx];
  endfunction

  function automatic bit offer_now(input int idx);
    return ((lcg_next(idx) >> 16) % (max_gap + 1)) == 0;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic push_item(input logic [W-1:0] a, input logic [W-1:0] b, input logic c);
    logic [W-1:0] expected;
    expected = c ? a + b : a - b;  // wraps at W bits
    a_q.push_back(a);
    b_q.push_back(b);
    c_q.push_back(c);
    model_q.push_back(expected);
  endtask

  task automatic push_random(input int n);
    logic [31:0]  hi;
    logic [31:0]  lo;
    logic [W-1:0] a;
    logic [W-1:0] b;
    for (int i = 0; i < n; i++) begin
      hi = lcg_next(0);
      lo = lcg_next(0);
      a  = {hi[31:16], lo[31:16]};
      hi = lcg_next(0);
      lo = lcg_next(0);
      b  = {hi[31:16], lo[31:16]};
      hi = lcg_next(0);
      push_item(a, b, hi[31]);
    end
  endtask

  task automatic wait_drain();
    while (model_q.size() != 0) @(posedge clk);
    repeat (DRAIN_IDLE) @(posedge clk);
  endtask

  // a new token only once the old one is gone
  always @(posedge clk) begin
    if (!reset) begin
      a_valid    <= 1'b0;
      b_valid    <= 1'b0;
      cond_valid <= 1'b0;
    end else begin
      if (a_xfer || !a_valid) begin
        a_valid <= 1'b0;
        if (a_q.size() != 0 && !hold_ab && offer_now(1)) begin
          a_data  <= a_q.pop_front();
          a_valid <= 1'b1;
        end
      end
      if (b_xfer || !b_valid) begin
        b_valid <= 1'b0;
        if (b_q.size() != 0 && !hold_ab && offer_now(2)) begin
          b_data  <= b_q.pop_front();
          b_valid <= 1'b1;
        end
      end
      if (c_xfer || !cond_valid) begin
        cond_valid <= 1'b0;
        if (c_q.size() != 0 && !hold_c && offer_now(3)) begin
          cond       <= c_q.pop_front();
          cond_valid <= 1'b1;
        end
      end
    end
  end

  // random result_ready runs of 1 to 20 cycles
  always @(posedge clk) begin
    if (!stall_en) begin
      result_ready <= 1'b1;
    end else if (rr_run != 0) begin
      rr_run <= rr_run - 1;
    end else begin
      rr_run       <= (lcg_next(4) >> 16) % 20;
      result_ready <= ((lcg_next(4) >> 20) & 1) != 0;
    end
  end

  // handshakes sampled mid-cycle complete on the next rising edge
  always @(negedge clk) begin
    a_xfer = a_valid && a_ready;
    b_xfer = b_valid && b_ready;
    c_xfer = cond_valid && cond_ready;
    if (reset && a_valid && !a_ready && !result_ready) a_blocked = 1'b1;
    if (reset && result_valid && result_ready) begin
      if (model_q.size() == 0) begin
        abort_run("Result transfer seen with no item outstanding");
      end else begin
        check_value("result", model_q.pop_front(), result);
        result_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
      abort_run($sformatf("Timeout after %0d cycles with results outstanding", cycle_count));
  end

  task automatic single_items();
    @(negedge clk);
    result_count = 0;
    push_item(32'hffff_fff0, 32'h0000_0025, 1'b1);  // sum wraps
    wait_drain();
    @(negedge clk);
    push_item(32'h0000_0010, 32'h0000_0025, 1'b0);  // difference wraps
    wait_drain();
    check_value("result_count", 2, result_count);
  endtask

  task automatic back_to_back_stream();
    @(negedge clk);
    result_count = 0;
    push_random(64);
    wait_drain();
    check_value("result_count", 64, result_count);
  endtask

  task automatic channel_skew();
    @(negedge clk);
    result_count = 0;
    max_gap      = 3;
    hold_ab      = 1'b1;  // cond runs ahead
    push_random(12);
    repeat (15) @(negedge clk);
    hold_ab = 1'b0;
    wait_drain();
    @(negedge clk);
    hold_c = 1'b1;  // operands run ahead
    push_random(12);
    repeat (15) @(negedge clk);
    hold_c = 1'b0;
    wait_drain();
    max_gap = 0;
    check_value("result_count", 24, result_count);
  endtask

  task automatic backpressure_stream();
    @(negedge clk);
    result_count = 0;
    a_blocked    = 1'b0;
    stall_en     = 1'b1;
    push_random(40);
    wait_drain();
    @(negedge clk);
    stall_en = 1'b0;
    check_value("a_ready_dropped", 1, a_blocked);
    check_value("result_count", 40, result_count);
  endtask

  task automatic reset_recovery();
    @(negedge clk);
    result_count = 0;
    push_random(16);
    while (result_count < 4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    a_q.delete();
    b_q.delete();
    c_q.delete();
    model_q.delete();
    @(negedge clk);  // reset edge has passed
    check_value("result_valid", 0, result_valid);
    repeat (3) @(posedge clk);
    reset <= 1'b1;
    @(negedge clk);
    check_value("result_valid", 0, result_valid);
    result_count = 0;
    push_random(8);
    wait_drain();
    check_value("result_count", 8, result_count);
  endtask

  initial begin
    lcg_state[0] = SEED;
    for (int i = 1; i < 5; i++) lcg_state[i] = lcg_next(0);
    repeat (5) @(posedge clk);
    reset <= 1'b1;
    single_items();
    back_to_back_stream();
    channel_skew();
    backpressure_stream();
    reset_recovery();
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== sim.f ====
design/dataflow_pkg.sv
design/eager_fork.sv
design/arith_branch.sv
design/antitoken_tracker.sv
design/speculative_select.sv
design/elastic_fifo.sv
design/spec_select_top.sv
dv/tb_spec_select.sv
